/* include/fm_sine_table.svh */
// quarter-wave sine magnitude table for the FM operator
// 256 entries of 12 bits, round(4095 * sin((i + 0.5) * pi / 512))
// built at elaboration from a constant function
`ifndef FM_SINE_TABLE_SVH
`define FM_SINE_TABLE_SVH

typedef logic [11:0] fm_sine_rom_t [256];

// one table entry, also usable by a reference model
function automatic logic [11:0] fm_sine_entry(input int i);
    real ang;
    ang = (real'(i) + 0.5) * 3.14159265358979 / 512.0;
    return 12'($rtoi(4095.0 * $sin(ang) + 0.5));
endfunction

// whole quarter wave
function automatic fm_sine_rom_t fm_sine_rom();
    fm_sine_rom_t rom;
    for (int i = 0; i < 256; i++) begin
        rom[i] = fm_sine_entry(i);
    end
    return rom;
endfunction

`endif

/* verilog/fm_pkg.sv */
// shared definitions of the FM tone generator
// frame and datapath sizes, register map
// envelope state and slot role enums
// slot parameter, operator and Wishbone request structs
package fm_pkg;

    localparam int num_slots  = 8;     // 4 channels x (modulator, carrier)
    localparam int num_chans  = 4;
    localparam int phase_bits = 20;
    localparam int index_bits = 10;
    localparam int att_bits   = 10;
    localparam int out_bits   = 14;
    localparam int mod_shift  = 3;     // modulator scaling into carrier index

    localparam logic [att_bits-1:0] att_max = 10'd1023;

    // register map, base addresses
    localparam logic [7:0] reg_status     = 8'h00;
    localparam logic [7:0] reg_timer_a    = 8'h01;
    localparam logic [7:0] reg_timer_ctrl = 8'h02;
    localparam logic [7:0] reg_keyon      = 8'h08;
    localparam logic [7:0] reg_fnum_lo    = 8'h10;  // + channel
    localparam logic [7:0] reg_chan_ctrl  = 8'h14;  // + channel
    localparam logic [7:0] reg_tl         = 8'h20;  // + slot
    localparam logic [7:0] reg_rate       = 8'h28;  // + slot
    localparam logic [7:0] reg_mul        = 8'h30;  // + slot

    typedef enum logic {env_attack, env_release} env_state_t;
    typedef enum logic {role_mod, role_car} slot_role_t;

    typedef struct packed {
        logic [2:0]  slot;
        slot_role_t  role;
        logic        keyon;
        logic [10:0] fnum;
        logic [3:0]  mul;
        logic [6:0]  tl;
        logic [3:0]  ar;       // attack rate
        logic [3:0]  rr;       // release rate
        logic        con;
        logic [1:0]  rl;       // bit 1 left, bit 0 right
        logic        valid;
    } slot_params_t;

    typedef struct packed {
        logic [2:0]            slot;
        slot_role_t            role;
        logic                  con;
        logic [1:0]            rl;
        logic [index_bits-1:0] index;
        logic [att_bits-1:0]   atten;
        logic                  valid;
    } op_in_t;

    typedef struct packed {
        logic [2:0]                 slot;
        slot_role_t                 role;
        logic                       con;
        logic [1:0]                 rl;
        logic signed [out_bits-1:0] data;
        logic                       valid;
    } op_out_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [7:0] adr;
        logic [7:0] dat;
    } wb_req_t;

endpackage

/* verilog/fm_regs.sv */
// Wishbone classic slave with the register file
// timer A control, key-on, per-channel and per-slot registers
// slot sequencer issuing one slot's parameters per clock
`timescale 1ns/10ps

module fm_regs (
    input  logic                 zero,
    input  logic                 rst_n,
    input  fm_pkg::wb_req_t      wb,
    output logic [7:0]           dat_o,
    output logic                 ack,
    output fm_pkg::slot_params_t params,
    output logic [9:0]           timer_value,
    output logic                 timer_run,
    output logic                 timer_irq_en,
    output logic                 timer_clr,
    input  logic                 timer_flag
);
    import fm_pkg::*;

    logic [2:0] slot_cnt;
    logic [7:0] timer_a;
    logic [3:0] keyon;
    logic [7:0] fnum_lo   [num_chans];
    logic [5:0] chan_ctrl [num_chans];   // rl, con, fnum high
    logic [6:0] tl        [num_slots];
    logic [7:0] rate      [num_slots];
    logic [3:0] mul       [num_slots];

    logic       access;
    logic       sel_fnum, sel_ctrl, sel_tl, sel_rate, sel_mul;
    logic [1:0] ch_sel;
    logic [2:0] sl_sel;
    logic [1:0] ch;
    logic [7:0] rdata;

    assign access = wb.cyc && wb.stb && !ack;
    assign ch_sel = wb.adr[1:0];
    assign sl_sel = wb.adr[2:0];
    assign ch     = slot_cnt[2:1];
    assign timer_value = {timer_a, 2'b00};

    always_comb begin
        sel_fnum = wb.adr[7:2] == reg_fnum_lo[7:2];
        sel_ctrl = wb.adr[7:2] == reg_chan_ctrl[7:2];
        sel_tl   = wb.adr[7:3] == reg_tl[7:3];
        sel_rate = wb.adr[7:3] == reg_rate[7:3];
        sel_mul  = wb.adr[7:3] == reg_mul[7:3];
    end

    always_comb begin
        rdata = 8'h00;
        if (wb.adr == reg_status)
            rdata = {7'b0, timer_flag};   // bit 7 stays 0
        else if (wb.adr == reg_timer_a)
            rdata = timer_a;
        else if (wb.adr == reg_timer_ctrl)
            rdata = {6'b0, timer_irq_en, timer_run};
        else if (wb.adr == reg_keyon)
            rdata = {4'b0, keyon};
        else if (sel_fnum)
            rdata = fnum_lo[ch_sel];
        else if (sel_ctrl)
            rdata = {2'b0, chan_ctrl[ch_sel]};
        else if (sel_tl)
            rdata = {1'b0, tl[sl_sel]};
        else if (sel_rate)
            rdata = rate[sl_sel];
        else if (sel_mul)
            rdata = {4'b0, mul[sl_sel]};
    end

    always_ff @(posedge zero) begin
        if (access)
            dat_o <= rdata;   // valid in the ack cycle
    end

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            ack          <= 1'b0;
            timer_a      <= '0;
            timer_run    <= 1'b0;
            timer_irq_en <= 1'b0;
            timer_clr    <= 1'b0;
            keyon        <= '0;
            for (int i = 0; i < num_chans; i++) begin
                fnum_lo[i]   <= '0;
                chan_ctrl[i] <= '0;
            end
            for (int i = 0; i < num_slots; i++) begin
                tl[i]   <= '0;
                rate[i] <= '0;
                mul[i]  <= '0;
            end
        end else begin
            ack       <= access;
            timer_clr <= 1'b0;   // one-clock strobe
            if (access && wb.we) begin
                if (wb.adr == reg_timer_a)
                    timer_a <= wb.dat;
                if (wb.adr == reg_timer_ctrl) begin
                    timer_run    <= wb.dat[0];
                    timer_irq_en <= wb.dat[1];
                    timer_clr    <= wb.dat[2];
                end
                if (wb.adr == reg_keyon)
                    keyon <= wb.dat[3:0];
                if (sel_fnum)
                    fnum_lo[ch_sel] <= wb.dat;
                if (sel_ctrl)
                    chan_ctrl[ch_sel] <= wb.dat[5:0];
                if (sel_tl)
                    tl[sl_sel] <= wb.dat[6:0];
                if (sel_rate)
                    rate[sl_sel] <= wb.dat;
                if (sel_mul)
                    mul[sl_sel] <= wb.dat[3:0];
            end
        end
    end

    // stage 1, parameters of the slot under the counter
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt <= '0;
            params   <= '0;
        end else begin
            slot_cnt <= slot_cnt + 3'd1;
            params   <= '{slot:  slot_cnt,
                          role:  slot_cnt[0] ? role_car : role_mod,
                          keyon: keyon[ch],
                          fnum:  {chan_ctrl[ch][2:0], fnum_lo[ch]},
                          mul:   mul[slot_cnt],
                          tl:    tl[slot_cnt],
                          ar:    rate[slot_cnt][7:4],
                          rr:    rate[slot_cnt][3:0],
                          con:   chan_ctrl[ch][3],
                          rl:    chan_ctrl[ch][5:4],
                          valid: 1'b1};
        end
    end

    ack_single: assert property (@(posedge zero) disable iff (!rst_n) ack |=> !ack);
    ack_has_stb: assert property (@(posedge zero) disable iff (!rst_n)
        ack |-> $past(wb.cyc && wb.stb) && wb.cyc && wb.stb);

endmodule

/* verilog/fm_timer.sv */
// timer A, counts samples up to 1023 and reloads
// sticky overflow flag and active low interrupt
`timescale 1ns/10ps

module fm_timer (
    input  logic       zero,
    input  logic       rst_n,
    input  logic       frame,    // sample strobe
    input  logic [9:0] value,
    input  logic       run,
    input  logic       irq_en,
    input  logic       clr,
    output logic       flag,
    output logic       irq_n
);
    logic [9:0] cnt;
    logic       ovf;

    assign ovf = run && frame && (cnt == 10'h3ff);

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            flag  <= 1'b0;
            irq_n <= 1'b1;
        end else begin
            if (!run)
                cnt <= value;       // held at the reload value while stopped
            else if (frame)
                cnt <= ovf ? value : cnt + 10'd1;
            if (ovf) begin
                flag <= 1'b1;
                if (irq_en)
                    irq_n <= 1'b0;
            end else if (clr) begin
                flag  <= 1'b0;
                irq_n <= 1'b1;
            end
        end
    end

    irq_needs_flag: assert property (@(posedge zero) disable iff (!rst_n) !irq_n |-> flag);

endmodule

/* verilog/fm_phase.sv */
// per-slot phase accumulators
// index taken from the phase before the step
// slot params delayed alongside
`timescale 1ns/10ps

module fm_phase (
    input  logic                 zero,
    input  logic                 rst_n,
    input  fm_pkg::slot_params_t params,
    output logic [9:0]           index,
    output fm_pkg::slot_params_t params_q
);
    import fm_pkg::*;

    logic [phase_bits-1:0] phase [num_slots];
    logic [14:0]           inc;

    // mul 0 acts as one half
    always_comb begin
        if (params.mul == 4'd0)
            inc = {5'b0, params.fnum[10:1]};
        else
            inc = params.fnum * params.mul;
    end

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            index    <= '0;
            params_q <= '0;
            for (int i = 0; i < num_slots; i++) begin
                phase[i] <= '0;
            end
        end else begin
            params_q <= params;
            if (params.valid) begin
                index <= phase[params.slot][phase_bits-1 -: index_bits];
                phase[params.slot] <= phase[params.slot] + inc;
            end
        end
    end

endmodule

/* verilog/fm_env.sv */
// per-slot envelope, attack while keyed on, release otherwise
// total attenuation adds 8 x tl, saturated
`timescale 1ns/10ps

module fm_env (
    input  logic                 zero,
    input  logic                 rst_n,
    input  fm_pkg::slot_params_t params,
    output logic [9:0]           atten,
    output fm_pkg::env_state_t   state
);
    import fm_pkg::*;

    logic [att_bits-1:0] att [num_slots];
    logic [att_bits-1:0] cur, nxt, ar8, rr8, tot_sat;
    logic [att_bits:0]   up, tot;   // one carry bit

    always_comb begin
        cur = att[params.slot];
        ar8 = {3'b000, params.ar, 3'b000};
        rr8 = {3'b000, params.rr, 3'b000};
        up  = {1'b0, cur} + {1'b0, rr8};
        if (params.keyon)
            nxt = (cur > ar8) ? cur - ar8 : '0;        // toward full level
        else
            nxt = (up > {1'b0, att_max}) ? att_max : up[att_bits-1:0];
        tot     = {1'b0, cur} + {1'b0, params.tl, 3'b000};
        tot_sat = (tot > {1'b0, att_max}) ? att_max : tot[att_bits-1:0];
    end

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            atten <= att_max;
            state <= env_release;
            for (int i = 0; i < num_slots; i++) begin
                att[i] <= att_max;   // silent
            end
        end else if (params.valid) begin
            atten           <= tot_sat;
            state           <= params.keyon ? env_attack : env_release;
            att[params.slot] <= nxt;
        end
    end

endmodule

/* verilog/fm_op.sv */
// two-operator FM operator
// carrier index offset by the channel's modulator output
// mirrored quarter-wave lookup and linear attenuation
`timescale 1ns/10ps

module fm_op (
    input  logic            zero,
    input  logic            rst_n,
    input  fm_pkg::op_in_t  op_in,
    output fm_pkg::op_out_t op_out
);
    import fm_pkg::*;
    `include "fm_sine_table.svh"

    localparam fm_sine_rom_t sine_rom = fm_sine_rom();

    logic signed [out_bits-1:0] mod_q;   // last modulator output
    logic [index_bits-1:0]      idx;
    logic [7:0]                 addr;
    logic [11:0]                mag;
    logic [att_bits-1:0]        gain;
    logic [21:0]                prod;
    logic signed [out_bits-1:0] value;

    always_comb begin
        idx = op_in.index;
        if (op_in.role == role_car)
            idx = op_in.index + 10'(mod_q >>> mod_shift);   // wraps
        addr  = idx[8] ? ~idx[7:0] : idx[7:0];   // second quarter mirrored
        mag   = sine_rom[addr];
        gain  = att_max - op_in.atten;
        prod  = mag * gain;
        value = $signed({2'b00, prod[21:10]});
        if (idx[9])
            value = -value;                      // negative half wave
    end

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            op_out <= '0;
            mod_q  <= '0;
        end else begin
            op_out <= '{slot: op_in.slot, role: op_in.role, con: op_in.con,
                        rl: op_in.rl, data: value, valid: op_in.valid};
            if (op_in.valid && op_in.role == role_mod)
                mod_q <= value;
        end
    end

endmodule

/* verilog/fm_mix.sv */
// stereo mixer, one left/right sample per frame
// carriers always, modulators too when con is set
`timescale 1ns/10ps

module fm_mix (
    input  logic               zero,
    input  logic               rst_n,
    input  fm_pkg::op_out_t    op_out,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);
    import fm_pkg::*;

    logic signed [15:0] acc_l, acc_r;
    logic signed [15:0] term, add_l, add_r;
    logic               audible, last;

    always_comb begin
        audible = op_out.valid && (op_out.role == role_car || op_out.con);
        last    = op_out.valid && op_out.slot == 3'(num_slots - 1);
        term    = {{2{op_out.data[out_bits-1]}}, op_out.data};
        add_l   = (audible && op_out.rl[1]) ? term : 16'sd0;
        add_r   = (audible && op_out.rl[0]) ? term : 16'sd0;
    end

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            acc_l  <= '0;
            acc_r  <= '0;
            left   <= '0;
            right  <= '0;
            sample <= 1'b0;
        end else begin
            sample <= last;
            if (last) begin
                left  <= acc_l + add_l;   // frame complete
                right <= acc_r + add_r;
                acc_l <= '0;
                acc_r <= '0;
            end else begin
                acc_l <= acc_l + add_l;
                acc_r <= acc_r + add_r;
            end
        end
    end

    sample_once: assert property (@(posedge zero) disable iff (!rst_n)
        sample |=> !sample [*7]);

endmodule

/* verilog/fm_synth.sv */
// FM tone generator top level
// register block, phase and envelope stage, operator, mixer
// timer A driven by the sample strobe
`timescale 1ns/10ps

module fm_synth (
    input  logic               zero,
    input  logic               rst_n,
    input  fm_pkg::wb_req_t    wb,
    output logic [7:0]         dat_o,
    output logic               ack,
    output logic               irq_n,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);
    import fm_pkg::*;

    slot_params_t          issue_params;   // stage 1
    slot_params_t          phase_params;   // stage 2
    logic [index_bits-1:0] index;
    logic [att_bits-1:0]   atten;
    op_in_t                op_in;
    op_out_t               op_out;

    logic [9:0] timer_value;
    logic       timer_run, timer_irq_en, timer_clr, timer_flag;

    fm_regs regs_i (
        .zero         ( zero          ),
        .rst_n        ( rst_n         ),
        .wb           ( wb            ),
        .dat_o        ( dat_o         ),
        .ack          ( ack           ),
        .params       ( issue_params  ),
        .timer_value  ( timer_value   ),
        .timer_run    ( timer_run     ),
        .timer_irq_en ( timer_irq_en  ),
        .timer_clr    ( timer_clr     ),
        .timer_flag   ( timer_flag    )
    );

    fm_phase phase_i (
        .zero     ( zero          ),
        .rst_n    ( rst_n         ),
        .params   ( issue_params  ),
        .index    ( index         ),
        .params_q ( phase_params  )
    );

    fm_env env_i (
        .zero   ( zero          ),
        .rst_n  ( rst_n         ),
        .params ( issue_params  ),
        .atten  ( atten         ),
        .state  (               )
    );

    // phase and envelope halves meet here
    assign op_in = '{slot: phase_params.slot, role: phase_params.role,
                     con: phase_params.con, rl: phase_params.rl,
                     index: index, atten: atten, valid: phase_params.valid};

    fm_op op_i (
        .zero   ( zero   ),
        .rst_n  ( rst_n  ),
        .op_in  ( op_in  ),
        .op_out ( op_out )
    );

    fm_mix mix_i (
        .zero   ( zero   ),
        .rst_n  ( rst_n  ),
        .op_out ( op_out ),
        .left   ( left   ),
        .right  ( right  ),
        .sample ( sample )
    );

    fm_timer timer_i (
        .zero   ( zero          ),
        .rst_n  ( rst_n         ),
        .frame  ( sample        ),
        .value  ( timer_value   ),
        .run    ( timer_run     ),
        .irq_en ( timer_irq_en  ),
        .clr    ( timer_clr     ),
        .flag   ( timer_flag    ),
        .irq_n  ( irq_n         )
    );

endmodule

/* bench/fm_synth_tb.sv */
// testbench for the FM tone generator
// stimulus/expect table applied in a loop over the Wishbone port
// cycle-level reference model of slots, phase, envelope, operator and mixer
// sample checker, timer interrupt tracking and a watchdog
`timescale 1ns/10ps

module fm_synth_tb;
    import fm_pkg::*;

    typedef enum logic [2:0] {op_wr, op_rd, op_irq, op_tmr, op_quiet} tb_op_t;

    typedef struct packed {
        tb_op_t      op;
        logic [7:0]  adr;
        logic [7:0]  dat;
        logic [7:0]  exp;      // read data, irq level or sample count
        logic [15:0] frames;   // samples to wait afterwards
    } entry_t;

    logic               zero;
    logic               rst_n;
    wb_req_t            wb;
    logic [7:0]         dat_o;
    logic               ack;
    logic               irq_n;
    logic signed [15:0] left, right;
    logic               sample;

    entry_t      table_q[$];
    logic [31:0] exp_q[$];      // {left, right} per frame
    logic [11:0] sine_q [256];
    int          errors, checks, xfers, ack_total, audible, since_run, irq_at;
    bit          quiet, irq_low_q;
    longint      run_limit;

    // model state and shadow registers
    int         m_slot, m_mod, m_left, m_right;
    bit         m_ack;
    int         m_phase [8];
    int         m_att [8];
    int         m_tl [8];
    int         m_mul [8];
    logic [7:0] m_rate [8];
    logic [7:0] m_fnum_lo [4];
    logic [7:0] m_ctrl [4];
    logic [3:0] m_keyon;

    fm_synth dut_i (
        .zero   ( zero   ),
        .rst_n  ( rst_n  ),
        .wb     ( wb     ),
        .dat_o  ( dat_o  ),
        .ack    ( ack    ),
        .irq_n  ( irq_n  ),
        .left   ( left   ),
        .right  ( right  ),
        .sample ( sample )
    );

    initial zero = 1'b0;
    always #2 zero = ~zero;

    // mirrored quarter wave, attenuated, signed
    function automatic int sine_level(input int idx, input int tot);
        int addr;
        int v;
        addr = ((idx & 256) != 0) ? 255 - (idx & 255) : (idx & 255);
        v = (int'(sine_q[addr]) * (1023 - tot)) >> 10;
        return ((idx & 512) != 0) ? -v : v;
    endfunction

    function automatic void shadow_write(input logic [7:0] adr, input logic [7:0] dat);
        if (adr == reg_keyon)
            m_keyon = dat[3:0];
        else if (adr[7:2] == reg_fnum_lo[7:2])
            m_fnum_lo[adr[1:0]] = dat;
        else if (adr[7:2] == reg_chan_ctrl[7:2])
            m_ctrl[adr[1:0]] = dat;
        else if (adr[7:3] == reg_tl[7:3])
            m_tl[adr[2:0]] = dat[6:0];
        else if (adr[7:3] == reg_rate[7:3])
            m_rate[adr[2:0]] = dat;
        else if (adr[7:3] == reg_mul[7:3])
            m_mul[adr[2:0]] = dat[3:0];
    endfunction

    // one slot per clock, output from the state before its step
    always @(posedge zero) begin : ref_model
        int         s, ch, idx, tot, outv, inc;
        logic [7:0] ctrl;
        if (!rst_n) begin
            m_slot = 0;
            m_mod = 0;
            m_left = 0;
            m_right = 0;
            m_ack = 1'b0;
            m_keyon = '0;
            for (int i = 0; i < 8; i++) begin
                m_phase[i] = 0;
                m_att[i] = 1023;
                m_tl[i] = 0;
                m_mul[i] = 0;
                m_rate[i] = '0;
            end
            for (int c = 0; c < 4; c++) begin
                m_fnum_lo[c] = '0;
                m_ctrl[c] = '0;
            end
        end else begin
            s = m_slot;
            ch = s / 2;
            ctrl = m_ctrl[ch];
            idx = m_phase[s] >> 10;
            if (s % 2 == 1)
                idx = (idx + (m_mod >>> mod_shift)) & 1023;   // carrier gets modulation
            tot = m_att[s] + 8 * m_tl[s];
            if (tot > 1023)
                tot = 1023;
            outv = sine_level(idx, tot);
            if (s % 2 == 0)
                m_mod = outv;
            if (s % 2 == 1 || ctrl[3]) begin
                if (ctrl[5])
                    m_left += outv;
                if (ctrl[4])
                    m_right += outv;
            end
            if (s == 7) begin
                exp_q.push_back({16'(m_left), 16'(m_right)});
                m_left = 0;
                m_right = 0;
            end
            inc = {ctrl[2:0], m_fnum_lo[ch]};
            inc = (m_mul[s] == 0) ? inc / 2 : inc * m_mul[s];
            m_phase[s] = (m_phase[s] + inc) % (1 << 20);
            if (m_keyon[ch])
                m_att[s] = (m_att[s] > 8 * m_rate[s][7:4]) ? m_att[s] - 8 * m_rate[s][7:4] : 0;
            else
                m_att[s] = (m_att[s] + 8 * m_rate[s][3:0] > 1023) ? 1023
                                                                 : m_att[s] + 8 * m_rate[s][3:0];
            m_slot = (s + 1) % 8;
            if (wb.cyc && wb.stb && wb.we && !m_ack)
                shadow_write(wb.adr, wb.dat);
            m_ack = wb.cyc && wb.stb && !m_ack;
        end
    end

    always @(negedge zero) begin : sample_check
        logic [31:0] want;
        if (rst_n && sample) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("sample strobe arrived with no frame from the model");
            end else begin
                want = exp_q.pop_front();
                checks += 2;
                if (left !== want[31:16]) begin
                    errors++;
                    $display("FAILED left: got 0x%h, expected 0x%h", left, want[31:16]);
                end
                if (right !== want[15:0]) begin
                    errors++;
                    $display("FAILED right: got 0x%h, expected 0x%h", right, want[15:0]);
                end
                if (quiet && (left !== 16'sd0 || right !== 16'sd0)) begin
                    errors++;
                    $display("output not silent while all keys are off");
                end
                if (!quiet && left != 16'sd0)
                    audible++;
            end
        end
    end

    // samples since run was written, and where irq_n first fell
    always @(negedge zero) begin
        if (rst_n) begin
            if (ack)
                ack_total++;
            if (ack && wb.we && wb.adr == reg_timer_ctrl && wb.dat[0])
                since_run = sample ? 1 : 0;
            else if (sample)
                since_run++;
            if (!irq_n && !irq_low_q)
                irq_at = since_run;
            irq_low_q = !irq_n;
        end
    end

    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdata);
        int waited;
        waited = 0;
        wb = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge zero);
            waited++;
        end while (!ack && waited < 8);
        if (!ack) begin
            errors++;
            $display("no ack on the bus for address 0x%h", adr);
        end
        rdata = dat_o;
        @(posedge zero);
        #1;
        wb = '0;
        @(negedge zero);
        if (ack) begin
            errors++;
            $display("ack held high for more than one cycle at address 0x%h", adr);
        end
        xfers++;
        @(posedge zero);
        #1;
    endtask

    task automatic wait_frames(input int n);
        if (n > 0) begin
            repeat (n) begin
                do begin
                    @(negedge zero);
                end while (!sample);
            end
            @(posedge zero);
            #1;
        end
    endtask

    task automatic add_entry(input tb_op_t op, input logic [7:0] adr, input logic [7:0] dat,
                             input logic [7:0] exp, input int frames);
        table_q.push_back('{op: op, adr: adr, dat: dat, exp: exp, frames: 16'(frames)});
    endtask

    task automatic build_table();
        logic [7:0] r;
        add_entry(op_rd, reg_status, 8'h00, 8'h00, 0);
        for (int i = 0; i < 8; i++) begin
            r = 8'($urandom);
            add_entry(op_wr, reg_tl + 8'(i), r, 8'h00, 0);
            add_entry(op_rd, reg_tl + 8'(i), 8'h00, {1'b0, r[6:0]}, 0);
            r = 8'($urandom);
            add_entry(op_wr, reg_rate + 8'(i), r, 8'h00, 0);
            add_entry(op_rd, reg_rate + 8'(i), 8'h00, r, 0);
            r = 8'($urandom);
            add_entry(op_wr, reg_mul + 8'(i), r, 8'h00, 0);
            add_entry(op_rd, reg_mul + 8'(i), 8'h00, {4'h0, r[3:0]}, 0);
        end
        for (int c = 0; c < 4; c++) begin
            r = 8'($urandom);
            add_entry(op_wr, reg_fnum_lo + 8'(c), r, 8'h00, 0);
            add_entry(op_rd, reg_fnum_lo + 8'(c), 8'h00, r, 0);
        end
        add_entry(op_quiet, 8'h00, 8'h01, 8'h00, 6);      // silence with keys off
        // ch0 carrier tone, left only, modulator nearly muted
        add_entry(op_wr, reg_fnum_lo, 8'h55, 8'h00, 0);
        add_entry(op_wr, reg_chan_ctrl, 8'h29, 8'h00, 0);
        add_entry(op_rd, reg_chan_ctrl, 8'h00, 8'h29, 0);
        add_entry(op_wr, reg_tl + 8'd0, 8'd127, 8'h00, 0);
        add_entry(op_wr, reg_tl + 8'd1, 8'd0, 8'h00, 0);
        for (int i = 0; i < 2; i++) begin
            add_entry(op_wr, reg_rate + 8'(i), 8'hf0, 8'h00, 0);
            add_entry(op_wr, reg_mul + 8'(i), 8'h01, 8'h00, 0);
        end
        add_entry(op_quiet, 8'h00, 8'h00, 8'h00, 0);
        add_entry(op_wr, reg_keyon, 8'h01, 8'h00, 40);
        // ch1 modulated, both sides, then con set
        add_entry(op_wr, reg_fnum_lo + 8'd1, 8'h00, 8'h00, 0);
        add_entry(op_wr, reg_chan_ctrl + 8'd1, 8'h32, 8'h00, 0);
        add_entry(op_wr, reg_tl + 8'd2, 8'd16, 8'h00, 0);
        add_entry(op_wr, reg_tl + 8'd3, 8'd0, 8'h00, 0);
        add_entry(op_wr, reg_rate + 8'd2, 8'hf0, 8'h00, 0);
        add_entry(op_wr, reg_rate + 8'd3, 8'hf0, 8'h00, 0);
        add_entry(op_wr, reg_mul + 8'd2, 8'h02, 8'h00, 0);
        add_entry(op_wr, reg_mul + 8'd3, 8'h01, 8'h00, 0);
        add_entry(op_wr, reg_keyon, 8'h03, 8'h00, 40);
        add_entry(op_wr, reg_chan_ctrl + 8'd1, 8'h3a, 8'h00, 20);
        // release down to silence
        for (int i = 0; i < 4; i++) begin
            add_entry(op_wr, reg_rate + 8'(i), 8'hf3, 8'h00, 0);
        end
        add_entry(op_wr, reg_keyon, 8'h00, 8'h00, 60);
        add_entry(op_quiet, 8'h00, 8'h01, 8'h00, 8);
        // timer A, 1024 - 0x3f0 = 16 samples
        add_entry(op_wr, reg_timer_a, 8'hfc, 8'h00, 0);
        add_entry(op_wr, reg_timer_ctrl, 8'h03, 8'h00, 18);
        add_entry(op_irq, 8'h00, 8'h00, 8'h00, 0);
        add_entry(op_tmr, 8'h00, 8'h00, 8'd16, 0);
        add_entry(op_rd, reg_status, 8'h00, 8'h01, 0);
        add_entry(op_wr, reg_timer_ctrl, 8'h04, 8'h00, 1);
        add_entry(op_irq, 8'h00, 8'h00, 8'h01, 0);
        add_entry(op_rd, reg_status, 8'h00, 8'h00, 0);
    endtask

    task automatic apply_entry(input entry_t e);
        logic [7:0] rdata;
        case (e.op)
            op_wr: bus_cycle(1'b1, e.adr, e.dat, rdata);
            op_rd: begin
                bus_cycle(1'b0, e.adr, 8'h00, rdata);
                checks++;
                if (rdata !== e.exp) begin
                    errors++;
                    $display("FAILED dat_o at 0x%h: got 0x%h, expected 0x%h", e.adr, rdata, e.exp);
                end
            end
            op_irq: begin
                checks++;
                if (irq_n !== e.exp[0]) begin
                    errors++;
                    $display("FAILED irq_n: got 0x%h, expected 0x%h", irq_n, e.exp[0]);
                end
            end
            op_tmr: begin
                checks++;
                if (irq_at != int'(e.exp)) begin
                    errors++;
                    $display("FAILED samples to irq_n: got 0x%h, expected 0x%h", irq_at, e.exp);
                end
            end
            op_quiet: quiet = e.dat[0];
            default: ;
        endcase
        wait_frames(e.frames);
    endtask

    initial begin : main
        longint frames_total;
        void'($urandom(32'h3ec3_dabc));
        rst_n = 1'b0;
        wb = '0;
        quiet = 1'b1;
        for (int i = 0; i < 256; i++) begin
            sine_q[i] = 12'($rtoi(4095.0 * $sin((real'(i) + 0.5) * 3.14159265358979 / 512.0) + 0.5));
        end
        build_table();
        frames_total = 0;
        foreach (table_q[i]) begin
            frames_total += table_q[i].frames;
        end
        run_limit = (frames_total * 8 + table_q.size() * 8 + 400) * 4;
        repeat (5) @(posedge zero);
        #1;
        rst_n = 1'b1;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        checks += 2;
        if (ack_total != xfers) begin
            errors++;
            $display("saw %0d acks for %0d bus transfers", ack_total, xfers);
        end
        if (audible == 0) begin
            errors++;
            $display("no audible samples during the tone tests");
        end
        $display("errors: %0d, checks: %0d, bus transfers: %0d", errors, checks, xfers);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (run_limit != 0);
        #(run_limit);
        $display("timeout at %0t before the table completed", $time);
        $display("errors: %0d, checks: %0d, bus transfers: %0d", errors + 1, checks, xfers);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
verilog/fm_pkg.sv
verilog/fm_regs.sv
verilog/fm_timer.sv
verilog/fm_phase.sv
verilog/fm_env.sv
verilog/fm_op.sv
verilog/fm_mix.sv
verilog/fm_synth.sv
bench/fm_synth_tb.sv
